// ==== hdl/scuDspPkg.sv ====
package scuDspPkg;

	// Operation word, cls 00
	typedef struct packed {
		logic [1:0] cls;
		logic [3:0] aluOp;
		logic       mulToP;
		logic       xRamToRx;
		logic       xRamToP;
		logic       rsvd22;
		logic [1:0] xSel;
		logic       yRamToRy;
		logic [1:0] acSel;
		logic       rsvd16;
		logic [1:0] ySel;
		logic [1:0] d1Op;
		logic [3:0] d1Dst;
		logic [7:0] d1Src;
	} opFieldsT;

	// MVI and control word, cls 10 and 11
	// For MVI, kind and mviDstLow form the destination code
	typedef struct packed {
		logic [1:0]  cls;
		logic [1:0]  kind;
		logic [1:0]  mviDstLow;
		logic        rsvd25;
		logic        condPol;
		logic [1:0]  rsvd23;
		logic        condC;
		logic        condS;
		logic        condZ;
		logic [10:0] rsvd18;
		logic [7:0]  target;
	} ctlFieldsT;

	typedef union packed {
		opFieldsT  op;
		ctlFieldsT ctl;
	} instrWordT;

	localparam logic [1:0] clsOp  = 2'b00;
	localparam logic [1:0] clsMvi = 2'b10;
	localparam logic [1:0] clsCtl = 2'b11;

	localparam logic [1:0] kindJmp  = 2'd0;
	localparam logic [1:0] kindEnd  = 2'd1;
	localparam logic [1:0] kindEndi = 2'd2;

	localparam logic [3:0] aluNop = 4'b0000;
	localparam logic [3:0] aluAnd = 4'b0001;
	localparam logic [3:0] aluOr  = 4'b0010;
	localparam logic [3:0] aluXor = 4'b0011;
	localparam logic [3:0] aluAdd = 4'b0100;
	localparam logic [3:0] aluSub = 4'b0101;
	localparam logic [3:0] aluAd2 = 4'b0110;
	localparam logic [3:0] aluSr  = 4'b1000;
	localparam logic [3:0] aluRr  = 4'b1001;
	localparam logic [3:0] aluSl  = 4'b1010;
	localparam logic [3:0] aluRl  = 4'b1011;
	localparam logic [3:0] aluRl8 = 4'b1111;

	localparam logic [1:0] acKeep  = 2'd0;
	localparam logic [1:0] acClear = 2'd1;
	localparam logic [1:0] acAlu   = 2'd2;
	localparam logic [1:0] acRam   = 2'd3;

	localparam logic [1:0] d1None = 2'd0;
	localparam logic [1:0] d1Imm  = 2'd1;
	localparam logic [1:0] d1Move = 2'd2;

	// D1 destinations, banks 0-3 and CT 12-15 by the top two bits
	localparam logic [1:0] dstBankHi = 2'b00;
	localparam logic [1:0] dstCtHi   = 2'b11;
	localparam logic [3:0] dstRx     = 4'd4;
	localparam logic [3:0] dstP      = 4'd5;

	localparam logic [3:0] srcAluLo = 4'd9;
	localparam logic [3:0] srcAluHi = 4'd10;

	localparam logic [1:0] regCtrl     = 2'd0;
	localparam logic [1:0] regPrg      = 2'd1;
	localparam logic [1:0] regDataAddr = 2'd2;
	localparam logic [1:0] regData     = 2'd3;

	localparam int statS  = 22;
	localparam int statZ  = 21;
	localparam int statC  = 20;
	localparam int statV  = 19;
	localparam int statE  = 18;
	localparam int statEx = 16;

	localparam int pcLoadBit = 15;
	localparam int execBit   = 16;

endpackage

// ==== hdl/dspRam.sv ====
`timescale 1ns/1ps

module dspRam #(
	parameter int addrWidth = 6,
	parameter int dataWidth = 32
) (
	input  logic                 CLK,
	input  logic [addrWidth-1:0] addr,
	input  logic [dataWidth-1:0] d,
	input  logic                 we,
	output logic [dataWidth-1:0] q
);

	logic [dataWidth-1:0] mem [2**addrWidth];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= d;
		end
	end

	assign q = mem[addr];

endmodule

// ==== hdl/hostPort.sv ====
`timescale 1ns/1ps

module hostPort (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic [1:0]  addr,
	input  logic        wr,
	input  logic [31:0] wdata,
	input  logic        req,
	input  logic        endExec,
	input  logic        endIrq,
	input  logic [3:0]  statusFlags,
	input  logic [7:0]  pc,
	input  logic [31:0] bankQ,
	output logic        ack,
	output logic [31:0] rdata,
	output logic        irq,
	output logic        run,
	output logic        pcLoad,
	output logic        prgWrite,
	output logic [31:0] hostData,
	output logic [7:0]  dataAddr,
	output logic        dataWrite,
	output logic        dataRead,
	output logic        clearV
);

	logic        access;
	logic        ctrlWrite;
	logic        statusRead;
	logic        eFlag;
	logic [31:0] status;

	// One access per request, at the edge that raises ack
	assign access     = req && !ack;
	assign ctrlWrite  = access && wr && addr == scuDspPkg::regCtrl;
	assign statusRead = access && !wr && addr == scuDspPkg::regCtrl;
	assign pcLoad     = ctrlWrite && !run && wdata[scuDspPkg::pcLoadBit];
	assign prgWrite   = access && wr && addr == scuDspPkg::regPrg && !run;
	assign dataWrite  = access && wr && addr == scuDspPkg::regData && !run;
	assign dataRead   = access && !wr && addr == scuDspPkg::regData && !run;
	assign clearV     = statusRead;
	assign hostData   = wdata;
	assign irq        = eFlag;

	always_comb begin
		status = '0;
		status[scuDspPkg::statS]  = statusFlags[3];
		status[scuDspPkg::statZ]  = statusFlags[2];
		status[scuDspPkg::statC]  = statusFlags[1];
		status[scuDspPkg::statV]  = statusFlags[0];
		status[scuDspPkg::statE]  = eFlag;
		status[scuDspPkg::statEx] = run;
		status[7:0] = pc;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ack <= 1'b0;
			run <= 1'b0;
			eFlag <= 1'b0;
			dataAddr <= '0;
		end else begin
			// ack follows req, which gives rise on access and fall on release
			ack <= req;
			if (endExec) begin
				run <= 1'b0;
			end
			if (ctrlWrite) begin
				run <= wdata[scuDspPkg::execBit];
			end
			if (statusRead) begin
				eFlag <= 1'b0;
			end
			if (endIrq) begin
				eFlag <= 1'b1;
			end
			if (access && wr && addr == scuDspPkg::regDataAddr) begin
				dataAddr <= wdata[7:0];
			end else if (dataWrite || dataRead) begin
				dataAddr <= dataAddr + 8'd1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (access && !wr) begin
			case (addr)
				scuDspPkg::regCtrl: rdata <= status;
				scuDspPkg::regData: rdata <= run ? '1 : bankQ;
				default:            rdata <= '0;
			endcase
		end
	end

	ackNeedsReq: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(ack) |-> $past(req));

endmodule

// ==== hdl/programSequencer.sv ====
`timescale 1ns/1ps

module programSequencer #(
	parameter int prgAddrWidth = 8
) (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic                    run,
	input  logic                    pcLoad,
	input  logic                    prgWrite,
	input  logic [31:0]             hostData,
	input  logic                    takeJump,
	input  logic [prgAddrWidth-1:0] jumpTarget,
	output logic [prgAddrWidth-1:0] pc,
	output scuDspPkg::instrWordT    ic
);

	logic [31:0] prgQ;

	dspRam #(
		.addrWidth(prgAddrWidth),
		.dataWidth(32)
	) prgRam_i (
		.CLK(CLK),
		.addr(pc),
		.d(hostData),
		.we(prgWrite),
		.q(prgQ)
	);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pc <= '0;
			ic <= '0;
		end else if (pcLoad) begin
			pc <= hostData[prgAddrWidth-1:0];
			ic <= '0;
		end else if (run) begin
			// Word after a jump is already in flight and runs as the delay slot
			ic <= prgQ;
			pc <= takeJump ? jumpTarget : pc + 1'b1;
		end else if (prgWrite) begin
			pc <= pc + 1'b1;
		end
	end

	pcHoldsWhenIdle: assert property (@(posedge CLK) disable iff (!RST_N)
		!run && !pcLoad && !prgWrite |=> $stable(pc));

endmodule

// ==== hdl/dspDecoder.sv ====
`timescale 1ns/1ps

module dspDecoder (
	input  scuDspPkg::instrWordT ic,
	input  logic                 run,
	input  logic                 flagS,
	input  logic                 flagZ,
	input  logic                 flagC,
	output logic                 aluEn,
	output logic [3:0]           aluOp,
	output logic                 rxFromX,
	output logic                 rxFromD1,
	output logic                 ryFromY,
	output logic [1:0]           acSel,
	output logic                 pFromMul,
	output logic                 pFromX,
	output logic                 pFromD1,
	output logic [1:0]           xSel,
	output logic [1:0]           ySel,
	output logic                 d1FromImm,
	output logic [31:0]          d1Imm,
	output logic [3:0]           d1Sel,
	output logic [3:0]           bankWrite,
	output logic [3:0]           ctInc,
	output logic [3:0]           ctWrite,
	output logic                 takeJump,
	output logic [7:0]           jumpTarget,
	output logic                 endExec,
	output logic                 endIrq
);

	logic       isOp;
	logic       isMvi;
	logic       isCtl;
	logic       d1Active;
	logic [3:0] d1Dst;
	logic       xRead;
	logic       yRead;
	logic       d1Read;
	logic [2:0] condFlags;

	assign isOp  = run && ic.op.cls == scuDspPkg::clsOp;
	assign isMvi = run && ic.ctl.cls == scuDspPkg::clsMvi;
	assign isCtl = run && ic.ctl.cls == scuDspPkg::clsCtl;

	// MVI rides the D1 path with its own destination and immediate
	assign d1Dst     = isMvi ? {ic.ctl.kind, ic.ctl.mviDstLow} : ic.op.d1Dst;
	assign d1Active  = isMvi || (isOp && ic.op.d1Op != scuDspPkg::d1None);
	assign d1FromImm = isMvi || (isOp && ic.op.d1Op == scuDspPkg::d1Imm);
	// MVI immediate overlaps the jump fields
	assign d1Imm = isMvi ? {{7{ic[24]}}, ic[24:0]} : {{24{ic.op.d1Src[7]}}, ic.op.d1Src};
	assign d1Sel = ic.op.d1Src[3:0];

	assign aluEn    = isOp && ic.op.aluOp != scuDspPkg::aluNop;
	assign aluOp    = ic.op.aluOp;
	assign rxFromX  = isOp && ic.op.xRamToRx;
	assign rxFromD1 = d1Active && d1Dst == scuDspPkg::dstRx;
	assign ryFromY  = isOp && ic.op.yRamToRy;
	assign acSel    = isOp ? ic.op.acSel : scuDspPkg::acKeep;
	assign pFromMul = isOp && ic.op.mulToP;
	assign pFromX   = isOp && ic.op.xRamToP;
	assign pFromD1  = d1Active && d1Dst == scuDspPkg::dstP;
	assign xSel     = ic.op.xSel;
	assign ySel     = ic.op.ySel;

	assign xRead  = isOp && (ic.op.xRamToRx || ic.op.xRamToP);
	assign yRead  = isOp && (ic.op.yRamToRy || ic.op.acSel == scuDspPkg::acRam);
	assign d1Read = isOp && ic.op.d1Op == scuDspPkg::d1Move && ic.op.d1Src[7:2] == '0;

	always_comb begin
		for (int n = 0; n < 4; n++) begin
			bankWrite[n] = d1Active && d1Dst == {scuDspPkg::dstBankHi, 2'(n)};
			ctWrite[n]   = d1Active && d1Dst == {scuDspPkg::dstCtHi, 2'(n)};
			ctInc[n]     = (xRead && xSel == 2'(n)) || (yRead && ySel == 2'(n))
				|| (d1Read && d1Sel[1:0] == 2'(n)) || bankWrite[n];
		end
	end

	// Any selected flag set, or all selected flags clear
	assign condFlags  = {ic.ctl.condC, ic.ctl.condS, ic.ctl.condZ} & {flagC, flagS, flagZ};
	assign takeJump   = isCtl && ic.ctl.kind == scuDspPkg::kindJmp
		&& (ic.ctl.condPol ? |condFlags : ~|condFlags);
	assign jumpTarget = ic.ctl.target;
	assign endExec    = isCtl && (ic.ctl.kind == scuDspPkg::kindEnd
		|| ic.ctl.kind == scuDspPkg::kindEndi);
	assign endIrq     = isCtl && ic.ctl.kind == scuDspPkg::kindEndi;

endmodule

// ==== hdl/dspAlu.sv ====
`timescale 1ns/1ps

module dspAlu (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        aluEn,
	input  logic [3:0]  aluOp,
	input  logic [47:0] ac,
	input  logic [47:0] p,
	input  logic        clearV,
	output logic [47:0] aluQ,
	output logic        flagS,
	output logic        flagZ,
	output logic        flagC,
	output logic        flagV
);

	logic carry;
	logic overflow;
	logic isAd2;

	always_comb begin
		aluQ = ac;
		carry = 1'b0;
		overflow = 1'b0;
		case (aluOp)
			scuDspPkg::aluAnd: aluQ[31:0] = ac[31:0] & p[31:0];
			scuDspPkg::aluOr:  aluQ[31:0] = ac[31:0] | p[31:0];
			scuDspPkg::aluXor: aluQ[31:0] = ac[31:0] ^ p[31:0];
			scuDspPkg::aluAdd: begin
				{carry, aluQ[31:0]} = {1'b0, ac[31:0]} + {1'b0, p[31:0]};
				overflow = (ac[31] == p[31]) && (aluQ[31] != ac[31]);
			end
			scuDspPkg::aluSub: begin
				{carry, aluQ[31:0]} = {1'b0, ac[31:0]} - {1'b0, p[31:0]};
				overflow = (ac[31] != p[31]) && (aluQ[31] != ac[31]);
			end
			scuDspPkg::aluAd2: begin
				{carry, aluQ} = {1'b0, ac} + {1'b0, p};
				overflow = (ac[47] == p[47]) && (aluQ[47] != ac[47]);
			end
			scuDspPkg::aluSr: {aluQ[31:0], carry} = {ac[31], ac[31:0]};
			scuDspPkg::aluRr: {aluQ[31:0], carry} = {ac[0], ac[31:0]};
			scuDspPkg::aluSl: {carry, aluQ[31:0]} = {ac[31:0], 1'b0};
			scuDspPkg::aluRl: {carry, aluQ[31:0]} = {ac[31:0], ac[31]};
			scuDspPkg::aluRl8: {carry, aluQ[31:0]} = {ac[24:0], ac[31:24]};
			default: ;
		endcase
	end

	assign isAd2 = aluOp == scuDspPkg::aluAd2;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			flagS <= 1'b0;
			flagZ <= 1'b0;
			flagC <= 1'b0;
			flagV <= 1'b0;
		end else begin
			if (aluEn) begin
				flagS <= isAd2 ? aluQ[47] : aluQ[31];
				flagZ <= isAd2 ? aluQ == '0 : aluQ[31:0] == '0;
				flagC <= carry;
			end
			// Sticky until a status read
			flagV <= (flagV && !clearV) || (aluEn && overflow);
		end
	end

	flagsHoldWithoutAlu: assert property (@(posedge CLK) disable iff (!RST_N)
		!aluEn |=> $stable({flagS, flagZ, flagC}));

endmodule

// ==== hdl/dspDataPath.sv ====
`timescale 1ns/1ps

module dspDataPath (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic [31:0] xBus,
	input  logic [31:0] yBus,
	input  logic [31:0] d1Bank,
	input  logic [47:0] aluQ,
	input  logic        rxFromX,
	input  logic        rxFromD1,
	input  logic        ryFromY,
	input  logic [1:0]  acSel,
	input  logic        pFromMul,
	input  logic        pFromX,
	input  logic        pFromD1,
	input  logic        d1FromImm,
	input  logic [31:0] d1Imm,
	input  logic [3:0]  d1Sel,
	output logic [47:0] ac,
	output logic [47:0] p,
	output logic [31:0] d1Bus
);

	logic [31:0]        rx;
	logic [31:0]        ry;
	logic signed [63:0] product;

	assign product = $signed(rx) * $signed(ry);

	always_comb begin
		if (d1FromImm) begin
			d1Bus = d1Imm;
		end else if (d1Sel == scuDspPkg::srcAluLo) begin
			d1Bus = aluQ[31:0];
		end else if (d1Sel == scuDspPkg::srcAluHi) begin
			d1Bus = aluQ[47:16];
		end else begin
			d1Bus = d1Bank;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rx <= '0;
			ry <= '0;
			ac <= '0;
			p <= '0;
		end else begin
			if (rxFromX) begin
				rx <= xBus;
			end else if (rxFromD1) begin
				rx <= d1Bus;
			end
			if (ryFromY) begin
				ry <= yBus;
			end
			case (acSel)
				scuDspPkg::acClear: ac <= '0;
				scuDspPkg::acAlu:   ac <= aluQ;
				scuDspPkg::acRam:   ac <= {{16{yBus[31]}}, yBus};
				default: ;
			endcase
			// Multiplier wins over the X bus, X bus over D1
			if (pFromMul) begin
				p <= product[47:0];
			end else if (pFromX) begin
				p <= {{16{xBus[31]}}, xBus};
			end else if (pFromD1) begin
				p <= {{16{d1Bus[31]}}, d1Bus};
			end
		end
	end

endmodule

// ==== hdl/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory #(
	parameter int ctWidth = 6
) (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               run,
	input  logic [1:0]         xSel,
	input  logic [1:0]         ySel,
	input  logic [3:0]         d1Sel,
	input  logic [3:0]         bankWrite,
	input  logic [3:0]         ctInc,
	input  logic [3:0]         ctWrite,
	input  logic [31:0]        d1Bus,
	input  logic [ctWidth+1:0] dataAddr,
	input  logic               dataWrite,
	input  logic               dataRead,
	input  logic [31:0]        hostData,
	output logic [31:0]        xBus,
	output logic [31:0]        yBus,
	output logic [31:0]        d1Bank,
	output logic [31:0]        bankQ
);

	logic [ctWidth-1:0] ct [4];
	logic [31:0]        bankOut [4];

	// Core owns the banks while running, host otherwise
	for (genvar n = 0; n < 4; n++) begin : gBank
		logic [ctWidth-1:0] ramAddr;
		logic [31:0]        ramData;
		logic               ramWe;

		assign ramAddr = run ? ct[n] : dataAddr[ctWidth-1:0];
		assign ramData = run ? d1Bus : hostData;
		assign ramWe   = run ? bankWrite[n] : dataWrite && dataAddr[ctWidth+1:ctWidth] == 2'(n);

		dspRam #(
			.addrWidth(ctWidth),
			.dataWidth(32)
		) bank_i (
			.CLK(CLK),
			.addr(ramAddr),
			.d(ramData),
			.we(ramWe),
			.q(bankOut[n])
		);
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int n = 0; n < 4; n++) begin
				ct[n] <= '0;
			end
		end else begin
			for (int n = 0; n < 4; n++) begin
				if (ctWrite[n]) begin
					ct[n] <= d1Bus[ctWidth-1:0];
				end else if (ctInc[n]) begin
					ct[n] <= ct[n] + 1'b1;
				end
			end
		end
	end

	assign xBus   = bankOut[xSel];
	assign yBus   = bankOut[ySel];
	assign d1Bank = bankOut[d1Sel[1:0]];
	assign bankQ  = bankOut[dataAddr[ctWidth+1:ctWidth]];

	// Host bank traffic never meets core bank traffic
	hostCoreExclusive: assert property (@(posedge CLK) disable iff (!RST_N)
		(dataWrite || dataRead) |-> ctInc == '0 && ctWrite == '0);

endmodule

// ==== hdl/scuDsp.sv ====
`timescale 1ns/1ps

module scuDsp #(
	parameter int prgAddrWidth = 8,
	parameter int ctWidth      = 6
) (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic [1:0]  addr,
	input  logic        wr,
	input  logic [31:0] wdata,
	input  logic        req,
	output logic        ack,
	output logic [31:0] rdata,
	output logic        irq
);

	logic                    run;
	logic                    pcLoad;
	logic                    prgWrite;
	logic [31:0]             hostData;
	logic [ctWidth+1:0]      dataAddr;
	logic                    dataWrite;
	logic                    dataRead;
	logic                    clearV;
	logic                    endExec;
	logic                    endIrq;
	logic [prgAddrWidth-1:0] pc;
	logic [31:0]             bankQ;
	scuDspPkg::instrWordT    ic;
	logic                    flagS;
	logic                    flagZ;
	logic                    flagC;
	logic                    flagV;
	logic                    aluEn;
	logic [3:0]              aluOp;
	logic                    rxFromX;
	logic                    rxFromD1;
	logic                    ryFromY;
	logic [1:0]              acSel;
	logic                    pFromMul;
	logic                    pFromX;
	logic                    pFromD1;
	logic [1:0]              xSel;
	logic [1:0]              ySel;
	logic                    d1FromImm;
	logic [31:0]             d1Imm;
	logic [3:0]              d1Sel;
	logic [3:0]              bankWrite;
	logic [3:0]              ctInc;
	logic [3:0]              ctWrite;
	logic                    takeJump;
	logic [prgAddrWidth-1:0] jumpTarget;
	logic [47:0]             aluQ;
	logic [47:0]             ac;
	logic [47:0]             p;
	logic [31:0]             xBus;
	logic [31:0]             yBus;
	logic [31:0]             d1Bank;
	logic [31:0]             d1Bus;

	hostPort hostPort_i (
		.CLK(CLK), .RST_N(RST_N), .addr(addr), .wr(wr), .wdata(wdata), .req(req),
		.endExec(endExec), .endIrq(endIrq), .statusFlags({flagS, flagZ, flagC, flagV}),
		.pc(pc), .bankQ(bankQ), .ack(ack), .rdata(rdata), .irq(irq), .run(run),
		.pcLoad(pcLoad), .prgWrite(prgWrite), .hostData(hostData), .dataAddr(dataAddr),
		.dataWrite(dataWrite), .dataRead(dataRead), .clearV(clearV)
	);

	programSequencer #(.prgAddrWidth(prgAddrWidth)) programSequencer_i (
		.CLK(CLK), .RST_N(RST_N), .run(run), .pcLoad(pcLoad), .prgWrite(prgWrite),
		.hostData(hostData), .takeJump(takeJump), .jumpTarget(jumpTarget), .pc(pc), .ic(ic)
	);

	dspDecoder dspDecoder_i (
		.ic(ic), .run(run), .flagS(flagS), .flagZ(flagZ), .flagC(flagC),
		.aluEn(aluEn), .aluOp(aluOp), .rxFromX(rxFromX), .rxFromD1(rxFromD1),
		.ryFromY(ryFromY), .acSel(acSel), .pFromMul(pFromMul), .pFromX(pFromX),
		.pFromD1(pFromD1), .xSel(xSel), .ySel(ySel), .d1FromImm(d1FromImm), .d1Imm(d1Imm),
		.d1Sel(d1Sel), .bankWrite(bankWrite), .ctInc(ctInc), .ctWrite(ctWrite),
		.takeJump(takeJump), .jumpTarget(jumpTarget), .endExec(endExec), .endIrq(endIrq)
	);

	dspAlu dspAlu_i (
		.CLK(CLK), .RST_N(RST_N), .aluEn(aluEn), .aluOp(aluOp), .ac(ac), .p(p),
		.clearV(clearV), .aluQ(aluQ), .flagS(flagS), .flagZ(flagZ), .flagC(flagC),
		.flagV(flagV)
	);

	dspDataPath dspDataPath_i (
		.CLK(CLK), .RST_N(RST_N), .xBus(xBus), .yBus(yBus), .d1Bank(d1Bank), .aluQ(aluQ),
		.rxFromX(rxFromX), .rxFromD1(rxFromD1), .ryFromY(ryFromY), .acSel(acSel),
		.pFromMul(pFromMul), .pFromX(pFromX), .pFromD1(pFromD1), .d1FromImm(d1FromImm),
		.d1Imm(d1Imm), .d1Sel(d1Sel), .ac(ac), .p(p), .d1Bus(d1Bus)
	);

	dataMemory #(.ctWidth(ctWidth)) dataMemory_i (
		.CLK(CLK), .RST_N(RST_N), .run(run), .xSel(xSel), .ySel(ySel), .d1Sel(d1Sel),
		.bankWrite(bankWrite), .ctInc(ctInc), .ctWrite(ctWrite), .d1Bus(d1Bus),
		.dataAddr(dataAddr), .dataWrite(dataWrite), .dataRead(dataRead),
		.hostData(hostData), .xBus(xBus), .yBus(yBus), .d1Bank(d1Bank), .bankQ(bankQ)
	);

endmodule

// ==== dv/scuDspTests.svh ====
// Instruction fields, OR-ed together into one operation word
function automatic logic [31:0] aluField(input logic [3:0] op);
	return {2'b00, op, 26'd0};
endfunction

function automatic logic [31:0] xField(input logic toRx, input logic toP, input logic [1:0] sel);
	logic [31:0] w;
	w = 32'd0;
	w[24] = toRx;
	w[23] = toP;
	w[21:20] = sel;
	return w;
endfunction

function automatic logic [31:0] yField(input logic toRy, input logic [1:0] acMode,
	input logic [1:0] sel);
	logic [31:0] w;
	w = 32'd0;
	w[19] = toRy;
	w[18:17] = acMode;
	w[15:14] = sel;
	return w;
endfunction

function automatic logic [31:0] mulField();
	return 32'd1 << 25;
endfunction

function automatic logic [31:0] d1Field(input logic [1:0] op, input logic [3:0] dst,
	input logic [7:0] src);
	return {18'd0, op, dst, src};
endfunction

function automatic logic [31:0] mviWord(input logic [3:0] dst, input logic [24:0] imm);
	return {2'b10, dst, 1'b0, imm};
endfunction

function automatic logic [31:0] jumpWord(input logic pol, input logic onC, input logic onS,
	input logic onZ, input logic [7:0] target);
	logic [31:0] w;
	w = {2'b11, 2'd0, 28'd0};
	w[24] = pol;
	w[21] = onC;
	w[20] = onS;
	w[19] = onZ;
	w[7:0] = target;
	return w;
endfunction

function automatic logic [31:0] endWord(input logic withIrq);
	return {2'b11, withIrq ? 2'd2 : 2'd1, 28'd0};
endfunction

// Expected {S, Z, C, result} for AC op P
function automatic logic [50:0] aluModel(input logic [3:0] op, input logic [47:0] a,
	input logic [47:0] b);
	logic [47:0] r;
	logic        c;
	logic        wide;
	r = a;
	c = 1'b0;
	wide = 1'b0;
	case (op)
		scuDspPkg::aluAnd: r[31:0] = a[31:0] & b[31:0];
		scuDspPkg::aluOr:  r[31:0] = a[31:0] | b[31:0];
		scuDspPkg::aluXor: r[31:0] = a[31:0] ^ b[31:0];
		scuDspPkg::aluAdd: {c, r[31:0]} = {1'b0, a[31:0]} + {1'b0, b[31:0]};
		scuDspPkg::aluSub: {c, r[31:0]} = {1'b0, a[31:0]} - {1'b0, b[31:0]};
		scuDspPkg::aluAd2: begin
			{c, r} = {1'b0, a} + {1'b0, b};
			wide = 1'b1;
		end
		scuDspPkg::aluSr: begin
			r[31:0] = {a[31], a[31:1]};
			c = a[0];
		end
		scuDspPkg::aluRr: begin
			r[31:0] = {a[0], a[31:1]};
			c = a[0];
		end
		scuDspPkg::aluSl: begin
			r[31:0] = {a[30:0], 1'b0};
			c = a[31];
		end
		scuDspPkg::aluRl: begin
			r[31:0] = {a[30:0], a[31]};
			c = a[31];
		end
		scuDspPkg::aluRl8: begin
			r[31:0] = {a[23:0], a[31:24]};
			c = a[24];
		end
		default: ;
	endcase
	return {wide ? r[47] : r[31], wide ? r == 48'd0 : r[31:0] == 32'd0, c, r};
endfunction

task automatic writeBank(input logic [1:0] bank, input logic [5:0] index, input logic [31:0] d);
	hostWrite(scuDspPkg::regDataAddr, {24'd0, bank, index});
	hostWrite(scuDspPkg::regData, d);
endtask

task automatic readBank(input logic [1:0] bank, input logic [5:0] index, output logic [31:0] d);
	hostWrite(scuDspPkg::regDataAddr, {24'd0, bank, index});
	hostRead(scuDspPkg::regData, d);
endtask

task automatic runProgram();
	hostWrite(scuDspPkg::regCtrl, 32'd1 << scuDspPkg::pcLoadBit);
	foreach (prog[i]) begin
		hostWrite(scuDspPkg::regPrg, prog[i]);
	end
	hostWrite(scuDspPkg::regCtrl, (32'd1 << scuDspPkg::execBit) | (32'd1 << scuDspPkg::pcLoadBit));
endtask

task automatic waitStopped(output logic [31:0] status);
	do begin
		hostRead(scuDspPkg::regCtrl, status);
	end while (status[scuDspPkg::statEx]);
endtask

task automatic waitIrq();
	while (!irq) begin
		@(negedge CLK);
	end
endtask

// Banks filled out of order, read back as one run across all four
task automatic bankLoadReadback();
	logic [31:0] image [256];
	int          bankOrder [4];
	logic [31:0] word;
	bankOrder = '{2, 0, 3, 1};
	foreach (bankOrder[k]) begin
		hostWrite(scuDspPkg::regDataAddr, 32'(bankOrder[k] * 64));
		for (int i = 0; i < 64; i++) begin
			image[bankOrder[k] * 64 + i] = $urandom();
			hostWrite(scuDspPkg::regData, image[bankOrder[k] * 64 + i]);
		end
	end
	hostWrite(scuDspPkg::regDataAddr, 32'd0);
	for (int i = 0; i < 256; i++) begin
		hostRead(scuDspPkg::regData, word);
		check(word, image[i], $sformatf("bank word %0d", i));
	end
endtask

task automatic moveImmediates();
	logic [24:0] immA;
	logic [24:0] immB;
	logic [7:0]  immC;
	logic [31:0] word;
	immA = 25'($urandom());
	immB = 25'($urandom());
	immC = 8'($urandom());
	prog.delete();
	prog.push_back(mviWord(4'd12, 25'd5));
	prog.push_back(mviWord(4'd13, 25'd10));
	prog.push_back(mviWord(4'd0, immA));
	prog.push_back(mviWord(4'd0, immB));
	prog.push_back(d1Field(scuDspPkg::d1Imm, 4'd1, immC));
	prog.push_back(endWord(1'b1));
	runProgram();
	waitIrq();
	hostRead(scuDspPkg::regCtrl, word);
	check(word[scuDspPkg::statEx], 1'b0, "EX after ENDI");
	check(word[scuDspPkg::statE], 1'b1, "E after ENDI");
	hostRead(scuDspPkg::regCtrl, word);
	check(word[scuDspPkg::statE], 1'b0, "E after status read");
	check(irq, 1'b0, "irq after status read");
	readBank(2'd0, 6'd5, word);
	check(word, {{7{immA[24]}}, immA}, "first MVI word");
	readBank(2'd0, 6'd6, word);
	check(word, {{7{immB[24]}}, immB}, "second MVI word");
	readBank(2'd1, 6'd10, word);
	check(word, {{24{immC[7]}}, immC}, "D1 immediate word");
endtask

task automatic aluOperations();
	logic [3:0]  ops [11];
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] word;
	logic [31:0] status;
	logic [50:0] model;
	ops = '{scuDspPkg::aluAnd, scuDspPkg::aluOr, scuDspPkg::aluXor, scuDspPkg::aluAdd,
		scuDspPkg::aluSub, scuDspPkg::aluAd2, scuDspPkg::aluSr, scuDspPkg::aluRr,
		scuDspPkg::aluSl, scuDspPkg::aluRl, scuDspPkg::aluRl8};
	foreach (ops[k]) begin
		a = $urandom();
		b = $urandom();
		writeBank(2'd1, 6'd0, a);
		writeBank(2'd0, 6'd0, b);
		prog.delete();
		prog.push_back(mviWord(4'd12, 25'd0));
		prog.push_back(mviWord(4'd13, 25'd0));
		prog.push_back(mviWord(4'd14, 25'd0));
		prog.push_back(xField(1'b0, 1'b1, 2'd0) | yField(1'b0, scuDspPkg::acRam, 2'd1));
		prog.push_back(aluField(ops[k]) | yField(1'b0, scuDspPkg::acAlu, 2'd0)
			| d1Field(scuDspPkg::d1Move, 4'd2, 8'd9));
		// NOP passes AC through, so this stores the upper half of the result
		prog.push_back(d1Field(scuDspPkg::d1Move, 4'd2, 8'd10));
		prog.push_back(endWord(1'b0));
		runProgram();
		waitStopped(status);
		model = aluModel(ops[k], {{16{a[31]}}, a}, {{16{b[31]}}, b});
		readBank(2'd2, 6'd0, word);
		check(word, model[31:0], $sformatf("ALU op %b low word", ops[k]));
		readBank(2'd2, 6'd1, word);
		check(word, model[47:16], $sformatf("ALU op %b high word", ops[k]));
		check(status[scuDspPkg::statS], model[50], $sformatf("ALU op %b S", ops[k]));
		check(status[scuDspPkg::statZ], model[49], $sformatf("ALU op %b Z", ops[k]));
		check(status[scuDspPkg::statC], model[48], $sformatf("ALU op %b C", ops[k]));
	end
endtask

task automatic multiplyToP();
	logic [31:0]        rxVal;
	logic [31:0]        ryVal;
	logic [31:0]        word;
	logic [31:0]        status;
	logic signed [63:0] product;
	rxVal = $urandom();
	ryVal = $urandom();
	writeBank(2'd0, 6'd0, rxVal);
	writeBank(2'd1, 6'd0, ryVal);
	prog.delete();
	prog.push_back(mviWord(4'd12, 25'd0));
	prog.push_back(mviWord(4'd13, 25'd0));
	prog.push_back(mviWord(4'd14, 25'd0));
	prog.push_back(xField(1'b1, 1'b0, 2'd0) | yField(1'b1, scuDspPkg::acKeep, 2'd1));
	prog.push_back(mulField() | yField(1'b0, scuDspPkg::acClear, 2'd0));
	prog.push_back(aluField(scuDspPkg::aluAd2) | yField(1'b0, scuDspPkg::acAlu, 2'd0)
		| d1Field(scuDspPkg::d1Move, 4'd2, 8'd9));
	prog.push_back(d1Field(scuDspPkg::d1Move, 4'd2, 8'd10));
	prog.push_back(endWord(1'b0));
	runProgram();
	waitStopped(status);
	product = $signed(rxVal) * $signed(ryVal);
	readBank(2'd2, 6'd0, word);
	check(word, product[31:0], "product low word");
	readBank(2'd2, 6'd1, word);
	check(word, product[47:16], "product high word");
endtask

// Jump at 4 goes to 8 when Z is set; slot 5 runs either way
task automatic jumpOnZero(input logic zeroFlag);
	logic [31:0] word;
	logic [31:0] status;
	prog.delete();
	prog.push_back(mviWord(4'd14, 25'd0));
	prog.push_back(mviWord(4'd5, zeroFlag ? 25'd0 : 25'd1));
	prog.push_back(yField(1'b0, scuDspPkg::acClear, 2'd0));
	prog.push_back(aluField(scuDspPkg::aluOr));
	prog.push_back(jumpWord(1'b1, 1'b0, 1'b0, 1'b1, 8'd8));
	prog.push_back(mviWord(4'd2, 25'h5a5));
	prog.push_back(mviWord(4'd2, 25'h111));
	prog.push_back(endWord(1'b0));
	prog.push_back(mviWord(4'd2, 25'h222));
	prog.push_back(endWord(1'b0));
	runProgram();
	waitStopped(status);
	readBank(2'd2, 6'd0, word);
	check(word, 32'h5a5, "delay slot marker");
	readBank(2'd2, 6'd1, word);
	check(word, zeroFlag ? 32'h222 : 32'h111, zeroFlag ? "taken path" : "fall-through path");
endtask

task automatic overflowSticky();
	logic [31:0] status;
	writeBank(2'd1, 6'd0, 32'h7fff_ffff);
	// Drops V left over from earlier programs
	hostRead(scuDspPkg::regCtrl, status);
	prog.delete();
	prog.push_back(mviWord(4'd13, 25'd0));
	prog.push_back(mviWord(4'd5, 25'd1));
	prog.push_back(yField(1'b0, scuDspPkg::acRam, 2'd1));
	prog.push_back(aluField(scuDspPkg::aluAdd));
	prog.push_back(mviWord(4'd5, 25'h1ff_ffff));
	prog.push_back(aluField(scuDspPkg::aluAdd));
	prog.push_back(endWord(1'b1));
	runProgram();
	waitIrq();
	hostRead(scuDspPkg::regCtrl, status);
	check(status[scuDspPkg::statV], 1'b1, "V after overflow");
	hostRead(scuDspPkg::regCtrl, status);
	check(status[scuDspPkg::statV], 1'b0, "V after status read");
endtask

// ==== dv/scuDspTb.sv ====
`timescale 1ns/1ps

module scuDspTb;

	localparam int timeoutCycles = 4000;

	logic        CLK;
	logic        RST_N;
	logic [1:0]  addr;
	logic        wr;
	logic [31:0] wdata;
	logic        req;
	logic        ack;
	logic [31:0] rdata;
	logic        irq;
	int          cycles = 0;
	// Program image for the next run, loaded at address 0
	logic [31:0] prog [$];

	scuDsp #(
		.prgAddrWidth(8),
		.ctWidth(6)
	) scuDsp_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.addr(addr),
		.wr(wr),
		.wdata(wdata),
		.req(req),
		.ack(ack),
		.rdata(rdata),
		.irq(irq)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#2 CLK = ~CLK;
		end
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= timeoutCycles) begin
			$display("Timeout: the run did not finish within %0d clock cycles", timeoutCycles);
			$display("Test FAILED");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Full four-phase cycle, entered and left just after a falling edge
	task automatic hostAccess(input logic [1:0] regAddr, input logic write,
		input logic [31:0] data, output logic [31:0] readData);
		addr = regAddr;
		wr = write;
		wdata = data;
		req = 1'b1;
		do begin
			@(negedge CLK);
		end while (!ack);
		readData = rdata;
		req = 1'b0;
		do begin
			@(negedge CLK);
		end while (ack);
	endtask

	task automatic hostWrite(input logic [1:0] regAddr, input logic [31:0] data);
		logic [31:0] discard;
		hostAccess(regAddr, 1'b1, data, discard);
	endtask

	task automatic hostRead(input logic [1:0] regAddr, output logic [31:0] data);
		hostAccess(regAddr, 1'b0, 32'd0, data);
	endtask

	`include "scuDspTests.svh"

	initial begin
		RST_N = 1'b0;
		addr = 2'd0;
		wr = 1'b0;
		wdata = 32'd0;
		req = 1'b0;
		void'($urandom(32'heb96cba6));
		repeat (16) @(negedge CLK);
		RST_N = 1'b1;
		@(negedge CLK);

		bankLoadReadback();
		moveImmediates();
		aluOperations();
		multiplyToP();
		jumpOnZero(1'b1);
		jumpOnZero(1'b0);
		overflowSticky();

		$display("Test OK");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+dv
hdl/scuDspPkg.sv
hdl/dspRam.sv
hdl/hostPort.sv
hdl/programSequencer.sv
hdl/dspDecoder.sv
hdl/dspAlu.sv
hdl/dspDataPath.sv
hdl/dataMemory.sv
hdl/scuDsp.sv
dv/scuDspTb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module scuDspTb -f project.f \
	-o scuDspSim > sim.log 2>&1 && ./obj_dir/scuDspSim >> sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
